// ==== source/coh_pkg.sv ====
package coh_pkg;

    localparam int ADDR_W = 32;  // Byte address, word aligned
    localparam int DATA_W = 32;  // One word per line

    // MESI line state
    typedef enum logic [1:0] {
        INVALID,
        SHARED,
        EXCLUSIVE,
        MODIFIED
    } mesi_t;

    // Snooping bus transactions
    typedef enum logic [1:0] {
        BUS_RD,    // Read miss
        BUS_RDX,   // Write miss, invalidate others
        BUS_UPGR,  // Write hit in S, invalidate others
        BUS_WB     // Dirty victim to L2
    } bus_op_t;

endpackage

// ==== source/l2_memory.sv ====
`timescale 1ns/1ps

module l2_memory #(
    parameter int MEM_WORDS  = 256,
    parameter int L2_LATENCY = 3
) (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       mem_ren,
    input  logic                       mem_wen,
    input  logic [coh_pkg::ADDR_W-1:0] mem_addr,
    input  logic [coh_pkg::DATA_W-1:0] mem_wdata,
    output logic [coh_pkg::DATA_W-1:0] mem_rdata,
    output logic                       mem_ready
);

    localparam int AW = $clog2(MEM_WORDS);
    localparam int CW = $clog2(L2_LATENCY + 1);

    logic [coh_pkg::DATA_W-1:0] mem [MEM_WORDS];
    logic [CW-1:0]              cnt;   // Cycles left on the pending read
    logic [AW-1:0]              widx;

    assign widx      = mem_addr[AW+1:2];   // Word index, wraps at MEM_WORDS
    assign mem_ready = (cnt == CW'(1));

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
            cnt <= '0;
        end else begin
            if (mem_wen)
                mem[widx] <= mem_wdata;          // Single cycle write
            if (mem_ren)
                cnt <= CW'(L2_LATENCY);
            else if (cnt != '0)
                cnt <= cnt - 1'b1;
        end
    end

    // Word captured at request, held until ready
    always_ff @(posedge CLK) begin
        if (mem_ren)
            mem_rdata <= mem[widx];
    end

endmodule

// ==== source/l1_dcache.sv ====
`timescale 1ns/1ps

module l1_dcache #(
    parameter int SETS = 8
) (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       ren,
    input  logic                       wen,
    input  logic [coh_pkg::ADDR_W-1:0] addr,
    input  logic [coh_pkg::DATA_W-1:0] wdata,
    output logic [coh_pkg::DATA_W-1:0] rdata,
    output logic                       busy,
    output logic                       hit,
    output coh_pkg::mesi_t             line_state,
    output logic                       victim_dirty,
    output logic [coh_pkg::ADDR_W-1:0] victim_addr,
    output logic [coh_pkg::DATA_W-1:0] victim_data,
    input  logic                       unit_done,
    input  logic                       fill_we,
    input  coh_pkg::mesi_t             fill_state,
    input  logic [coh_pkg::DATA_W-1:0] fill_data,
    input  logic                       state_we,
    input  coh_pkg::mesi_t             new_state,
    input  logic                       snoop_valid,
    input  logic [coh_pkg::ADDR_W-1:0] snoop_addr,
    input  coh_pkg::bus_op_t           snoop_op,
    output logic                       snoop_hit,
    output logic                       snoop_dirty,
    output logic [coh_pkg::DATA_W-1:0] snoop_data
);

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = coh_pkg::ADDR_W - IDX_W - 2;

    logic [TAG_W-1:0]           tag_arr   [SETS];
    logic [coh_pkg::DATA_W-1:0] data_arr  [SETS];
    coh_pkg::mesi_t             state_arr [SETS];

    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] snp_idx;
    logic [TAG_W-1:0] tag;
    logic [TAG_W-1:0] snp_tag;
    coh_pkg::mesi_t   cur_state;
    coh_pkg::mesi_t   snp_state;
    logic             snoop_conflict;
    logic             serve;           // Access completes from the array this cycle

    // Processor side lookup
    assign idx       = addr[IDX_W+1:2];
    assign tag       = addr[coh_pkg::ADDR_W-1:IDX_W+2];
    assign cur_state = state_arr[idx];
    assign hit       = (cur_state != coh_pkg::INVALID) && (tag_arr[idx] == tag);
    assign line_state = hit ? cur_state : coh_pkg::INVALID;
    assign rdata     = data_arr[idx];

    // Victim is whatever sits at the index, only looked at on a miss
    assign victim_dirty = (cur_state == coh_pkg::MODIFIED);
    assign victim_addr  = {tag_arr[idx], idx, 2'b00};
    assign victim_data  = data_arr[idx];

    // Snoop side lookup
    assign snp_idx     = snoop_addr[IDX_W+1:2];
    assign snp_tag     = snoop_addr[coh_pkg::ADDR_W-1:IDX_W+2];
    assign snp_state   = state_arr[snp_idx];
    assign snoop_hit   = (snp_state != coh_pkg::INVALID) && (tag_arr[snp_idx] == snp_tag);
    assign snoop_dirty = snoop_hit && (snp_state == coh_pkg::MODIFIED);
    assign snoop_data  = data_arr[snp_idx];

    // Snoop to our index wins, the core retries next cycle
    assign snoop_conflict = snoop_valid && (snp_idx == idx);

    // Read hit, or write hit in E/M; write in S needs an upgrade
    assign serve = hit && !snoop_conflict && (ren || (cur_state != coh_pkg::SHARED));
    assign busy  = (ren || wen) && !serve && !unit_done;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SETS; i++) begin
                state_arr[i] <= coh_pkg::INVALID;
            end
        end else begin
            if (snoop_valid && snoop_hit) begin
                if (snoop_op == coh_pkg::BUS_RD)
                    state_arr[snp_idx] <= coh_pkg::SHARED;   // M/E drop to S
                else
                    state_arr[snp_idx] <= coh_pkg::INVALID;  // RDX or UPGR from the other core
            end
            if (fill_we)
                state_arr[idx] <= fill_state;
            else if (state_we)
                state_arr[idx] <= new_state;                 // Upgrade S to M
            else if (serve && wen)
                state_arr[idx] <= coh_pkg::MODIFIED;         // Silent E to M
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_we) begin
            tag_arr[idx]  <= tag;
            data_arr[idx] <= fill_data;
        end else if (serve && wen) begin
            data_arr[idx] <= wdata;
        end
    end

endmodule

// ==== source/coherence_unit.sv ====
`timescale 1ns/1ps

module coherence_unit (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       ren,
    input  logic                       wen,
    input  logic [coh_pkg::ADDR_W-1:0] addr,
    input  logic [coh_pkg::DATA_W-1:0] wdata,
    input  logic                       hit,
    input  coh_pkg::mesi_t             line_state,
    input  logic                       victim_dirty,
    input  logic [coh_pkg::ADDR_W-1:0] victim_addr,
    input  logic [coh_pkg::DATA_W-1:0] victim_data,
    output logic                       unit_done,
    output logic                       fill_we,
    output coh_pkg::mesi_t             fill_state,
    output logic [coh_pkg::DATA_W-1:0] fill_data,
    output logic                       state_we,
    output coh_pkg::mesi_t             new_state,
    output logic                       bus_req,
    output coh_pkg::bus_op_t           bus_op,
    output logic [coh_pkg::ADDR_W-1:0] bus_addr,
    output logic [coh_pkg::DATA_W-1:0] bus_wdata,
    input  logic                       bus_done,
    input  logic [coh_pkg::DATA_W-1:0] bus_rdata,
    input  logic                       bus_exclusive
);

    typedef enum logic [2:0] {
        IDLE,
        WB_REQ,     // Dirty victim out first
        FILL_REQ,
        UPGR_REQ,
        COMPLETE    // Line installed, release the core
    } state_t;

    state_t state, next;

    always_comb begin
        next = state;
        case (state)
            IDLE: begin
                if ((ren || wen) && !hit)
                    next = victim_dirty ? WB_REQ : FILL_REQ;
                else if (wen && hit && (line_state == coh_pkg::SHARED))
                    next = UPGR_REQ;
            end
            WB_REQ:   if (bus_done) next = FILL_REQ;
            FILL_REQ: if (bus_done) next = COMPLETE;
            UPGR_REQ: if (bus_done) next = COMPLETE;
            default:  next = IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n)
            state <= IDLE;
        else
            state <= next;
    end

    // Request held until bus_done
    assign bus_req   = (state == WB_REQ) || (state == FILL_REQ) || (state == UPGR_REQ);
    assign bus_addr  = (state == WB_REQ) ? victim_addr : addr;
    assign bus_wdata = victim_data;

    always_comb begin
        case (state)
            WB_REQ:   bus_op = coh_pkg::BUS_WB;
            UPGR_REQ: bus_op = coh_pkg::BUS_UPGR;
            default:  bus_op = wen ? coh_pkg::BUS_RDX : coh_pkg::BUS_RD;
        endcase
    end

    // Upgrade lost its S copy while waiting, so take the returned word instead
    assign fill_we   = bus_done && ((state == FILL_REQ) || ((state == UPGR_REQ) && !hit));
    assign state_we  = bus_done && (state == UPGR_REQ) && hit;
    assign new_state = coh_pkg::MODIFIED;

    always_comb begin
        if (wen)
            fill_state = coh_pkg::MODIFIED;
        else if (bus_exclusive)
            fill_state = coh_pkg::EXCLUSIVE;   // No other copy
        else
            fill_state = coh_pkg::SHARED;
    end

    assign fill_data = wen ? wdata : bus_rdata;  // Whole word, so write merges trivially
    assign unit_done = (state == COMPLETE);

endmodule

// ==== source/bus_ctrl.sv ====
`timescale 1ns/1ps

module bus_ctrl #(
    parameter int L2_LATENCY = 3
) (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       bus_req0,
    input  coh_pkg::bus_op_t           bus_op0,
    input  logic [coh_pkg::ADDR_W-1:0] bus_addr0,
    input  logic [coh_pkg::DATA_W-1:0] bus_wdata0,
    input  logic                       bus_req1,
    input  coh_pkg::bus_op_t           bus_op1,
    input  logic [coh_pkg::ADDR_W-1:0] bus_addr1,
    input  logic [coh_pkg::DATA_W-1:0] bus_wdata1,
    output logic                       bus_done0,
    output logic                       bus_done1,
    output logic [coh_pkg::DATA_W-1:0] bus_rdata,
    output logic                       bus_exclusive,
    output logic                       snoop_valid0,
    output logic                       snoop_valid1,
    output logic [coh_pkg::ADDR_W-1:0] snoop_addr,
    output coh_pkg::bus_op_t           snoop_op,
    input  logic                       snoop_hit0,
    input  logic                       snoop_dirty0,
    input  logic [coh_pkg::DATA_W-1:0] snoop_data0,
    input  logic                       snoop_hit1,
    input  logic                       snoop_dirty1,
    input  logic [coh_pkg::DATA_W-1:0] snoop_data1,
    output logic                       mem_ren,
    output logic                       mem_wen,
    output logic [coh_pkg::ADDR_W-1:0] mem_addr,
    output logic [coh_pkg::DATA_W-1:0] mem_wdata,
    input  logic [coh_pkg::DATA_W-1:0] mem_rdata,
    input  logic                       mem_ready
);

    typedef enum logic [2:0] {
        IDLE,
        GRANT,
        SNOOP,
        READ_L2,
        WRITE_L2,   // Writeback or dirty snoop copy, done here
        RESPOND
    } state_t;

    state_t state, next;

    logic                       gnt;       // Core being served, also the round-robin pointer
    logic                       pick;
    logic                       shared_q;  // Other cache held the line
    coh_pkg::bus_op_t           op_q;
    logic [coh_pkg::ADDR_W-1:0] addr_q;
    logic [coh_pkg::DATA_W-1:0] data_q;
    logic                       s_hit;
    logic                       s_dirty;
    logic [coh_pkg::DATA_W-1:0] s_data;
    logic                       done;

    // Tie goes to the core not served last
    assign pick = (bus_req0 && bus_req1) ? ~gnt : bus_req1;

    // Snoop answer from the non-granted cache
    assign s_hit   = gnt ? snoop_hit0   : snoop_hit1;
    assign s_dirty = gnt ? snoop_dirty0 : snoop_dirty1;
    assign s_data  = gnt ? snoop_data0  : snoop_data1;

    always_comb begin
        next = state;
        case (state)
            IDLE:     if (bus_req0 || bus_req1) next = GRANT;
            GRANT:    next = (op_q == coh_pkg::BUS_WB) ? WRITE_L2 : SNOOP;
            SNOOP:    next = s_dirty ? WRITE_L2 : READ_L2;
            READ_L2:  if (mem_ready) next = RESPOND;
            default:  next = IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            gnt      <= 1'b1;    // Core 0 wins the first tie
            shared_q <= 1'b0;
        end else begin
            state <= next;
            if (state == IDLE && (bus_req0 || bus_req1))
                gnt <= pick;
            if (state == SNOOP)
                shared_q <= s_hit;
        end
    end

    // Transaction payload
    always_ff @(posedge CLK) begin
        if (state == IDLE) begin
            op_q   <= pick ? bus_op1    : bus_op0;
            addr_q <= pick ? bus_addr1  : bus_addr0;
            data_q <= pick ? bus_wdata1 : bus_wdata0;
        end else if (state == SNOOP && s_dirty) begin
            data_q <= s_data;                 // Cache to cache, also written to L2
        end else if (state == READ_L2 && mem_ready) begin
            data_q <= mem_rdata;
        end
    end

    assign done      = (state == WRITE_L2) || (state == RESPOND);
    assign bus_done0 = done && !gnt;
    assign bus_done1 = done && gnt;
    assign bus_rdata = data_q;
    assign bus_exclusive = !shared_q;

    assign snoop_valid0 = (state == SNOOP) && gnt;
    assign snoop_valid1 = (state == SNOOP) && !gnt;
    assign snoop_addr   = addr_q;
    assign snoop_op     = op_q;

    // Clean snoop, so L2 supplies the word; UPGR too, in case our S copy was lost
    assign mem_ren   = (state == SNOOP) && !s_dirty;
    assign mem_wen   = (state == WRITE_L2);
    assign mem_addr  = addr_q;
    assign mem_wdata = data_q;

endmodule

// ==== source/coh_top.sv ====
`timescale 1ns/1ps

module coh_top #(
    parameter int SETS       = 8,
    parameter int MEM_WORDS  = 256,
    parameter int L2_LATENCY = 3
) (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       cpu0_ren,
    input  logic                       cpu0_wen,
    input  logic [coh_pkg::ADDR_W-1:0] cpu0_addr,
    input  logic [coh_pkg::DATA_W-1:0] cpu0_wdata,
    output logic [coh_pkg::DATA_W-1:0] cpu0_rdata,
    output logic                       cpu0_busy,
    input  logic                       cpu1_ren,
    input  logic                       cpu1_wen,
    input  logic [coh_pkg::ADDR_W-1:0] cpu1_addr,
    input  logic [coh_pkg::DATA_W-1:0] cpu1_wdata,
    output logic [coh_pkg::DATA_W-1:0] cpu1_rdata,
    output logic                       cpu1_busy
);

    // Per core nets, index is the core number
    logic [1:0]                 ren, wen, busy, hit, victim_dirty, unit_done;
    logic [1:0]                 fill_we, state_we, bus_req, bus_done;
    logic [1:0]                 snoop_valid, snoop_hit, snoop_dirty;
    logic [coh_pkg::ADDR_W-1:0] addr [2];
    logic [coh_pkg::ADDR_W-1:0] victim_addr [2];
    logic [coh_pkg::ADDR_W-1:0] bus_addr [2];
    logic [coh_pkg::DATA_W-1:0] wdata [2];
    logic [coh_pkg::DATA_W-1:0] rdata [2];
    logic [coh_pkg::DATA_W-1:0] victim_data [2];
    logic [coh_pkg::DATA_W-1:0] fill_data [2];
    logic [coh_pkg::DATA_W-1:0] bus_wdata [2];
    logic [coh_pkg::DATA_W-1:0] snoop_data [2];
    coh_pkg::mesi_t             line_state [2];
    coh_pkg::mesi_t             fill_state [2];
    coh_pkg::mesi_t             new_state [2];
    coh_pkg::bus_op_t           bus_op [2];

    // Shared bus and L2 nets
    logic [coh_pkg::DATA_W-1:0] bus_rdata, mem_rdata, mem_wdata;
    logic [coh_pkg::ADDR_W-1:0] snoop_addr, mem_addr;
    logic                       bus_exclusive, mem_ren, mem_wen, mem_ready;
    coh_pkg::bus_op_t           snoop_op;

    assign ren   = {cpu1_ren, cpu0_ren};
    assign wen   = {cpu1_wen, cpu0_wen};
    assign addr  = '{cpu0_addr, cpu1_addr};
    assign wdata = '{cpu0_wdata, cpu1_wdata};
    assign cpu0_rdata = rdata[0];
    assign cpu1_rdata = rdata[1];
    assign cpu0_busy  = busy[0];
    assign cpu1_busy  = busy[1];

    for (genvar g = 0; g < 2; g++) begin : g_core
        l1_dcache #(.SETS(SETS)) u_cache (
            .CLK(CLK), .rst_n(rst_n), .ren(ren[g]), .wen(wen[g]),
            .addr(addr[g]), .wdata(wdata[g]), .rdata(rdata[g]), .busy(busy[g]),
            .hit(hit[g]), .line_state(line_state[g]), .victim_dirty(victim_dirty[g]),
            .victim_addr(victim_addr[g]), .victim_data(victim_data[g]),
            .unit_done(unit_done[g]), .fill_we(fill_we[g]), .fill_state(fill_state[g]),
            .fill_data(fill_data[g]), .state_we(state_we[g]), .new_state(new_state[g]),
            .snoop_valid(snoop_valid[g]), .snoop_addr(snoop_addr), .snoop_op(snoop_op),
            .snoop_hit(snoop_hit[g]), .snoop_dirty(snoop_dirty[g]),
            .snoop_data(snoop_data[g])
        );

        coherence_unit u_unit (
            .CLK(CLK), .rst_n(rst_n), .ren(ren[g]), .wen(wen[g]),
            .addr(addr[g]), .wdata(wdata[g]), .hit(hit[g]), .line_state(line_state[g]),
            .victim_dirty(victim_dirty[g]), .victim_addr(victim_addr[g]),
            .victim_data(victim_data[g]), .unit_done(unit_done[g]),
            .fill_we(fill_we[g]), .fill_state(fill_state[g]), .fill_data(fill_data[g]),
            .state_we(state_we[g]), .new_state(new_state[g]), .bus_req(bus_req[g]),
            .bus_op(bus_op[g]), .bus_addr(bus_addr[g]), .bus_wdata(bus_wdata[g]),
            .bus_done(bus_done[g]), .bus_rdata(bus_rdata), .bus_exclusive(bus_exclusive)
        );
    end

    bus_ctrl #(.L2_LATENCY(L2_LATENCY)) u_bus (
        .CLK(CLK), .rst_n(rst_n),
        .bus_req0(bus_req[0]), .bus_op0(bus_op[0]), .bus_addr0(bus_addr[0]),
        .bus_wdata0(bus_wdata[0]), .bus_req1(bus_req[1]), .bus_op1(bus_op[1]),
        .bus_addr1(bus_addr[1]), .bus_wdata1(bus_wdata[1]),
        .bus_done0(bus_done[0]), .bus_done1(bus_done[1]),
        .bus_rdata(bus_rdata), .bus_exclusive(bus_exclusive),
        .snoop_valid0(snoop_valid[0]), .snoop_valid1(snoop_valid[1]),
        .snoop_addr(snoop_addr), .snoop_op(snoop_op),
        .snoop_hit0(snoop_hit[0]), .snoop_dirty0(snoop_dirty[0]), .snoop_data0(snoop_data[0]),
        .snoop_hit1(snoop_hit[1]), .snoop_dirty1(snoop_dirty[1]), .snoop_data1(snoop_data[1]),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ready(mem_ready)
    );

    l2_memory #(.MEM_WORDS(MEM_WORDS), .L2_LATENCY(L2_LATENCY)) u_l2 (
        .CLK(CLK), .rst_n(rst_n), .mem_ren(mem_ren), .mem_wen(mem_wen),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata), .mem_ready(mem_ready)
    );

endmodule

// ==== sim/coh_assertions.sv ====
`timescale 1ns/1ps

module coh_assertions (
    input logic CLK,
    input logic rst_n,
    input logic bus_req0,
    input logic bus_req1,
    input logic bus_done0,
    input logic bus_done1,
    input logic snoop_valid0,
    input logic snoop_valid1,
    input logic mem_ren,
    input logic mem_wen
);

    int fail_count = 0;  // Failed assertion count

    // One completion per cycle
    done_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
        !(bus_done0 && bus_done1))
        else begin
            fail_count++;
            $error("bus_done0 and bus_done1 high in the same cycle");
        end

    // Done pulse only to a core holding its request
    done0_req: assert property (@(posedge CLK) disable iff (!rst_n) bus_done0 |-> bus_req0)
        else begin
            fail_count++;
            $error("bus_done0 without bus_req0");
        end
    done1_req: assert property (@(posedge CLK) disable iff (!rst_n) bus_done1 |-> bus_req1)
        else begin
            fail_count++;
            $error("bus_done1 without bus_req1");
        end

    // Snoop goes to the other cache, so the served core is requesting
    snoop_other: assert property (@(posedge CLK) disable iff (!rst_n)
        !(snoop_valid0 && snoop_valid1) &&
        (snoop_valid0 -> bus_req1) && (snoop_valid1 -> bus_req0))
        else begin
            fail_count++;
            $error("Snoop sent to the requesting core");
        end

    // L2 read and write never overlap
    mem_excl: assert property (@(posedge CLK) disable iff (!rst_n) !(mem_ren && mem_wen))
        else begin
            fail_count++;
            $error("mem_ren and mem_wen high together");
        end

endmodule

bind bus_ctrl coh_assertions u_bus_checks (
    .CLK(CLK),
    .rst_n(rst_n),
    .bus_req0(bus_req0),
    .bus_req1(bus_req1),
    .bus_done0(bus_done0),
    .bus_done1(bus_done1),
    .snoop_valid0(snoop_valid0),
    .snoop_valid1(snoop_valid1),
    .mem_ren(mem_ren),
    .mem_wen(mem_wen)
);

// ==== sim/tb_coh.sv ====
`timescale 1ns/1ps

module tb_coh;

    localparam int CLK_PERIOD = 40;
    localparam int N_RAND     = 150;              // Random ops per core
    localparam int TOTAL_OPS  = 18 + 2 * N_RAND;  // Directed plus random

    logic        CLK = 1'b0;
    logic        rst_n;
    logic [1:0]  ren, wen, busy;
    logic [31:0] addr  [2];
    logic [31:0] wdata [2];
    logic [31:0] rdata [2];

    logic [31:0] model [256];    // Flat word memory, mirrors L2 size
    int          errors = 0;
    int          checks = 0;
    integer      seed = 25967;

    // Pre-drawn random traffic, per core
    bit          r_wr   [2][N_RAND];
    logic [31:0] r_addr [2][N_RAND];
    logic [31:0] r_data [2][N_RAND];
    int          r_gap  [2][N_RAND];

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    coh_top #(.SETS(8), .MEM_WORDS(256), .L2_LATENCY(3)) UUT (
        .CLK(CLK), .rst_n(rst_n),
        .cpu0_ren(ren[0]), .cpu0_wen(wen[0]), .cpu0_addr(addr[0]), .cpu0_wdata(wdata[0]),
        .cpu0_rdata(rdata[0]), .cpu0_busy(busy[0]),
        .cpu1_ren(ren[1]), .cpu1_wen(wen[1]), .cpu1_addr(addr[1]), .cpu1_wdata(wdata[1]),
        .cpu1_rdata(rdata[1]), .cpu1_busy(busy[1])
    );

    // 4 indexes x 4 tags, lots of conflict misses
    function automatic logic [31:0] pool_addr(input logic [31:0] r);
        logic [7:0] w;
        w = {3'b000, r[3:2], 1'b0, r[1:0]};
        return {22'b0, w, 2'b00};
    endfunction

    // Called and returns 2 ns after a rising edge
    task automatic access(input int c, input bit wr, input logic [31:0] a,
                          input logic [31:0] d, input string name, input bit fast);
        int          waits;
        logic [31:0] expv;
        waits    = 0;
        ren[c]   = !wr;
        wen[c]   = wr;
        addr[c]  = a;
        wdata[c] = d;
        @(negedge CLK);                    // Request cycle, outputs settled
        while (busy[c]) begin
            waits++;
            @(negedge CLK);
        end
        if (fast) begin
            checks++;
            if (waits != 0) begin
                errors++;
                $display("%s: hit to a modified line stalled for %0d cycles", name, waits);
            end
        end
        if (!wr) begin
            expv = model[a[9:2]];
            checks++;
            if (rdata[c] !== expv) begin
                errors++;
                $display("mismatch %s: expected %h, actual %h", name, expv, rdata[c]);
            end
        end
        @(posedge CLK);
        if (wr)
            model[a[9:2]] = d;             // Visible to reads of later cycles only
        #2;
        ren[c] = 1'b0;
        wen[c] = 1'b0;
    endtask

    task automatic run_core(input int c);
        for (int i = 0; i < N_RAND; i++) begin
            repeat (r_gap[c][i]) begin
                @(posedge CLK);
                #2;
            end
            access(c, r_wr[c][i], r_addr[c][i], r_data[c][i],
                   $sformatf("random core%0d op%0d", c, i), 1'b0);
        end
    endtask

    // Watchdog, generous per-op budget
    initial begin
        #(TOTAL_OPS * 30 * CLK_PERIOD);
        $display("Timeout: run still going after %0d ns", TOTAL_OPS * 30 * CLK_PERIOD);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        ren   = 2'b00;
        wen   = 2'b00;
        for (int c = 0; c < 2; c++) begin
            addr[c]  = '0;
            wdata[c] = '0;
        end
        for (int i = 0; i < 256; i++)
            model[i] = '0;
        for (int i = 0; i < N_RAND; i++) begin
            for (int c = 0; c < 2; c++) begin
                r_wr[c][i]   = $random(seed) & 1;
                r_addr[c][i] = pool_addr($random(seed));
                r_data[c][i] = $random(seed);
                r_gap[c][i]  = ($random(seed) & 32'h7) % 3;  // 0 to 2 idle cycles
            end
        end
        repeat (3) @(posedge CLK);
        #2;
        rst_n = 1'b1;

        // Reset state, idle and L2 cleared
        @(negedge CLK);
        checks++;
        if (busy !== 2'b00) begin
            errors++;
            $display("busy not low while idle after reset (busy=%b)", busy);
        end
        @(posedge CLK);
        #2;
        access(0, 1'b0, 32'h40, '0, "reset read core0", 1'b0);
        access(1, 1'b0, 32'h3C, '0, "reset read core1", 1'b0);

        // Single core, then a hit on the M line
        access(0, 1'b1, 32'h10, 32'h1111_0001, "write core0", 1'b0);
        access(0, 1'b0, 32'h10, '0, "read back core0", 1'b0);
        access(0, 1'b1, 32'h10, 32'h1111_0002, "write hit in M", 1'b1);
        access(0, 1'b0, 32'h10, '0, "read after M hit", 1'b0);

        // Dirty line moves between cores
        access(0, 1'b1, 32'h20, 32'h2222_0001, "xcore write core0", 1'b0);
        access(1, 1'b0, 32'h20, '0, "xcore read core1", 1'b0);
        access(1, 1'b1, 32'h20, 32'h2222_0002, "xcore write core1", 1'b0);
        access(0, 1'b0, 32'h20, '0, "xcore read core0", 1'b0);

        // Same index, second write evicts a dirty victim
        access(0, 1'b1, 32'h04, 32'h3333_0001, "evict write a", 1'b0);
        access(0, 1'b1, 32'h24, 32'h3333_0002, "evict write b", 1'b0);
        access(0, 1'b0, 32'h04, '0, "evict read a", 1'b0);
        access(0, 1'b0, 32'h24, '0, "evict read b", 1'b0);

        // Shared copies, then upgrade by core 1
        access(0, 1'b0, 32'h0C, '0, "shared read core0", 1'b0);
        access(1, 1'b0, 32'h0C, '0, "shared read core1", 1'b0);
        access(1, 1'b1, 32'h0C, 32'h4444_0001, "upgrade write core1", 1'b0);
        access(0, 1'b0, 32'h0C, '0, "read after upgrade", 1'b0);

        // Both cores at once
        fork
            run_core(0);
            run_core(1);
        join

        repeat (2) @(posedge CLK);
        errors = errors + UUT.u_bus.u_bus_checks.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
source/coh_pkg.sv
source/l2_memory.sv
source/l1_dcache.sv
source/coherence_unit.sv
source/bus_ctrl.sv
source/coh_top.sv
sim/coh_assertions.sv
sim/tb_coh.sv
